// File: sim.f
source/icache_pkg.sv
source/icache_tag_store.sv
source/icache_line_store.sv
source/icache_ctrl.sv
source/icache_top.sv
bench/tb_clock.sv
bench/fill_memory.sv
bench/icache_chk.sv
bench/icache_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module icache_tb -Mdir obj_dir -f sim.f
	./obj_dir/Vicache_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/icache_tb.sv
// Testbench for the four-way L1 instruction cache.
// Runs directed fetch sequences against a tag and pseudo-LRU reference model.
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    logic                   clk;
    logic                   arst_n;
    logic                   fetch_valid;
    icache_pkg::fetch_req_t fetch_req;
    logic                   rsp_valid;
    icache_pkg::fetch_rsp_t rsp;
    logic                   busy;
    logic                   flush;
    logic                   fill_req_valid;
    icache_pkg::fill_req_t  fill_req;
    logic                   fill_valid;
    icache_pkg::fill_rsp_t  fill_rsp;

    // reference model of tags, valid bits and tree bits per set.
    logic [25:0] ref_tag   [4][4];
    logic [3:0]  ref_valid [4];
    logic        ref_root  [4];
    logic        ref_left  [4];
    logic        ref_right [4];

    int          errors = 0;
    int          checks = 0;
    int          refill_count = 0;
    logic [1:0]  last_refill_way = 2'd0;
    logic [15:0] lfsr;

    tb_clock clock0 (
        .clk    (clk),
        .arst_n (arst_n)
    );

    icache_top dut0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .busy           (busy),
        .flush          (flush),
        .fill_req_valid (fill_req_valid),
        .fill_req       (fill_req),
        .fill_valid     (fill_valid),
        .fill_rsp       (fill_rsp)
    );

    fill_memory #(.delay(3)) mem0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .fill_req_valid (fill_req_valid),
        .fill_req       (fill_req),
        .fill_valid     (fill_valid),
        .fill_rsp       (fill_rsp)
    );

    // records which way each refill writes, observed on the internal refill strobe.
    always @(posedge clk) begin
        if (dut0.refill_valid) begin
            refill_count    <= refill_count + 1;
            last_refill_way <= dut0.refill_way;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // 16-bit Galois LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [1:0] victim_of(input logic [1:0] s);
        victim_of = ref_root[s] ? {1'b1, ref_right[s]} : {1'b0, ref_left[s]};
    endfunction

    // tree update of the replacement table, pointing away from the touched way.
    task automatic touch_model(input logic [1:0] s, input logic [1:0] w);
        case (w)
            2'd0: begin ref_root[s] = 1'b1; ref_left[s] = 1'b1; end
            2'd1: begin ref_root[s] = 1'b1; ref_left[s] = 1'b0; end
            2'd2: begin ref_root[s] = 1'b0; ref_right[s] = 1'b1; end
            default: begin ref_root[s] = 1'b0; ref_right[s] = 1'b0; end
        endcase
    endtask

    task automatic clear_model();
        for (int s = 0; s < 4; s++) begin
            ref_valid[s] = '0;
            ref_root[s]  = 1'b0;
            ref_left[s]  = 1'b0;
            ref_right[s] = 1'b0;
        end
    endtask

    // waits for the cache to go idle, returning on a falling edge.
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout: cache stayed busy for %0d cycles", n);
            errors++;
        end
    endtask

    // issues one fetch, checks the response against the model and updates the model.
    // on a miss the returned way is the one the cache actually refilled.
    task automatic fetch_and_check(input logic [31:0] pc, output logic got_hit,
                                   output logic [1:0] way);
        logic [1:0]  idx;
        logic [25:0] tag;
        logic        exp_hit;
        logic [1:0]  exp_way;
        int          fills_before;
        int          cycles;
        idx     = pc[5:4];
        tag     = pc[31:6];
        exp_hit = 1'b0;
        exp_way = victim_of(idx);
        for (int w = 0; w < 4; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                exp_hit = 1'b1;
                exp_way = w[1:0];
            end
        end
        wait_idle();
        fills_before = refill_count;
        fetch_valid  = 1'b1;
        fetch_req.pc = pc;
        @(negedge clk);
        fetch_valid = 1'b0;
        fetch_req   = '0;
        // the fetch was taken on the last rising edge, so the cache is busy now.
        check_value("busy", 32'(busy), 32'd1);
        cycles      = 1;
        while (!rsp_valid && cycles < 64) begin
            @(negedge clk);
            cycles++;
        end
        if (!rsp_valid) begin
            $display("timeout: no response to the fetch of pc 0x%08h", pc);
            errors++;
        end else begin
            check_value("rsp.instr", rsp.instr, ~pc);
            check_value("rsp.hit", 32'(rsp.hit), 32'(exp_hit));
            check_value("refill count", refill_count - fills_before, exp_hit ? 0 : 1);
            if (exp_hit) begin
                check_value("hit latency", cycles, 2);
            end else begin
                check_value("refill_way", 32'(last_refill_way), 32'(exp_way));
            end
        end
        if (!exp_hit) begin
            ref_tag[idx][exp_way]   = tag;
            ref_valid[idx][exp_way] = 1'b1;
        end
        touch_model(idx, exp_way);
        got_hit = rsp.hit;
        way     = exp_hit ? exp_way : last_refill_way;
    endtask

    task automatic flush_cache();
        wait_idle();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        clear_model();
    endtask

    task automatic after_reset_checks();
        int         n;
        logic       h;
        logic [1:0] w;
        n = 0;
        while (arst_n !== 1'b1 && n < 32) begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        check_value("fill_req_valid", 32'(fill_req_valid), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        fetch_and_check(32'h0000_0100, h, w);
        check_value("first fetch hit", 32'(h), 32'd0);
    endtask

    // every word of the line refilled above hits.
    task automatic line_hits();
        logic       h;
        logic [1:0] w;
        for (int i = 0; i < 4; i++) begin
            fetch_and_check(32'h0000_010C - 32'(4 * i), h, w);
            check_value("line word hit", 32'(h), 32'd1);
        end
    endtask

    // four tags of set 1 land in ways 0, 2, 1 and 3.
    task automatic set_fill_order();
        logic       h;
        logic [1:0] w;
        logic [1:0] order [4];
        order = '{2'd0, 2'd2, 2'd1, 2'd3};
        for (int i = 0; i < 4; i++) begin
            fetch_and_check(32'h0000_1010 + 32'(i * 32'h1000), h, w);
            check_value("fill order way", 32'(w), 32'(order[i]));
        end
        for (int i = 0; i < 4; i++) begin
            fetch_and_check(32'h0000_1014 + 32'(i * 32'h1000), h, w);
            check_value("filled set hit", 32'(h), 32'd1);
        end
    endtask

    // touching ways 1, 0 and 3 leaves way 1 as the victim of the fifth tag.
    task automatic replacement_order();
        logic       h;
        logic [1:0] w;
        fetch_and_check(32'h0000_3010, h, w);
        fetch_and_check(32'h0000_1010, h, w);
        fetch_and_check(32'h0000_4010, h, w);
        fetch_and_check(32'h0000_5010, h, w);
        check_value("evicted way", 32'(w), 32'd1);
        fetch_and_check(32'h0000_1018, h, w);
        check_value("kept tag hit", 32'(h), 32'd1);
        fetch_and_check(32'h0000_2018, h, w);
        check_value("kept tag hit", 32'(h), 32'd1);
        fetch_and_check(32'h0000_4018, h, w);
        check_value("kept tag hit", 32'(h), 32'd1);
        fetch_and_check(32'h0000_3018, h, w);
        check_value("evicted tag hit", 32'(h), 32'd0);
    endtask

    task automatic flush_restart();
        logic       h;
        logic [1:0] w;
        flush_cache();
        fetch_and_check(32'h0000_1010, h, w);
        check_value("hit after flush", 32'(h), 32'd0);
        check_value("way after flush", 32'(w), 32'd0);
        fetch_and_check(32'h0000_0104, h, w);
        check_value("hit after flush", 32'(h), 32'd0);
        check_value("way after flush", 32'(w), 32'd0);
    endtask

    // word-aligned addresses below 0x200 give eight tags per set, forcing evictions.
    task automatic random_fetches();
        logic [31:0] r;
        logic        h;
        logic [1:0]  w;
        for (int i = 0; i < 300; i++) begin
            take_bits(7, r);
            fetch_and_check(r << 2, h, w);
        end
    endtask

    initial begin
        fetch_valid = 1'b0;
        fetch_req   = '0;
        flush       = 1'b0;
        lfsr        = 16'd22437;
        clear_model();
        after_reset_checks();
        line_hits();
        set_fill_order();
        replacement_order();
        flush_restart();
        random_fetches();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/icache_chk.sv
// Protocol assertions for the cache controller.
// Bound into every icache_ctrl instance.
`timescale 1ns/1ps
`default_nettype none

module icache_chk (
    input wire logic                    clk,
    input wire logic                    arst_n,
    input wire icache_pkg::ctrl_state_t state,
    input wire logic                    hit,
    input wire logic                    lookup_valid,
    input wire logic                    rsp_valid,
    input wire icache_pkg::fetch_rsp_t  rsp,
    input wire logic                    fill_req_valid,
    input wire logic                    busy
);

    // the response strobe is a single-cycle pulse.
    rsp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid stayed high for more than one cycle");

    // a refill is only requested right after a lookup that missed.
    fill_after_miss: assert property (@(posedge clk) disable iff (!arst_n)
        fill_req_valid |-> ($past(state) == icache_pkg::LOOKUP) && !$past(hit))
        else $error("fill_req_valid without a missed lookup");

    // a hit found one cycle after the lookup is answered in the next cycle.
    hit_in_two: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(lookup_valid) && hit) |=> (rsp_valid && rsp.hit))
        else $error("hit response did not follow the fetch by two cycles");

    // nothing is in flight in the first cycle after reset.
    idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> (!busy && !rsp_valid && !fill_req_valid))
        else $error("cache not idle after reset");

endmodule

bind icache_ctrl icache_chk chk0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .state          (state),
    .hit            (hit),
    .lookup_valid   (lookup_valid),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp),
    .fill_req_valid (fill_req_valid),
    .busy           (busy)
);

`default_nettype wire

// File: bench/fill_memory.sv
// Backing memory model for the cache refill port.
// Answers each line request after a fixed delay with words derived from their addresses.
`timescale 1ns/1ps
`default_nettype none

module fill_memory #(
    parameter int delay = 3
) (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  fill_req_valid,
    input  wire icache_pkg::fill_req_t fill_req,
    output logic                       fill_valid,
    output icache_pkg::fill_rsp_t      fill_rsp
);

    logic [31:0] base;

    initial begin
        fill_valid = 1'b0;
        fill_rsp   = '0;
        forever begin
            @(posedge clk);
            if (arst_n && fill_req_valid) begin
                base = {fill_req.line_addr, 4'h0};
                // the line is driven on a falling edge so it is sampled delay edges later.
                repeat (delay - 1) @(posedge clk);
                @(negedge clk);
                // every word holds the inverse of its own byte address.
                for (int i = 0; i < 4; i++) begin
                    fill_rsp.line[i * 32 +: 32] = ~(base + 32'(4 * i));
                end
                fill_valid = 1'b1;
                @(negedge clk);
                fill_valid = 1'b0;
                fill_rsp   = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// Clock and reset source for the instruction cache testbench.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    // 4 ns period, reset held for five rising edges and released on a falling edge.
    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: source/icache_top.sv
// Top level of the four-way L1 instruction cache.
// Connects the controller with the tag store and the line store.
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   fetch_valid,
    input  wire icache_pkg::fetch_req_t fetch_req,
    output logic                        rsp_valid,
    output icache_pkg::fetch_rsp_t      rsp,
    output logic                        busy,
    input  wire logic                   flush,
    output logic                        fill_req_valid,
    output icache_pkg::fill_req_t       fill_req,
    input  wire logic                   fill_valid,
    input  wire icache_pkg::fill_rsp_t  fill_rsp
);

    // lookup sent to both stores in parallel.
    logic                lookup_valid;
    icache_pkg::lookup_t lookup;
    logic [1:0]          word_sel;

    // results of the tag store.
    logic                         hit;
    logic [icache_pkg::way_w-1:0] hit_way;
    logic [icache_pkg::way_w-1:0] victim_way;

    // one candidate word per way from the line store.
    logic [icache_pkg::ways-1:0][icache_pkg::word_w-1:0] way_words;

    // refill write shared by both stores.
    logic                         refill_valid;
    logic [icache_pkg::way_w-1:0] refill_way;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .busy           (busy),
        .lookup_valid   (lookup_valid),
        .lookup         (lookup),
        .word_sel       (word_sel),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .way_words      (way_words),
        .refill_valid   (refill_valid),
        .refill_way     (refill_way),
        .fill_req_valid (fill_req_valid),
        .fill_req       (fill_req),
        .fill_valid     (fill_valid),
        .fill_rsp       (fill_rsp)
    );

    // flush only touches validity and replacement state.
    icache_tag_store u_tag_store (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .refill_valid (refill_valid),
        .refill_way   (refill_way)
    );

    icache_line_store u_line_store (
        .clk          (clk),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .word_sel     (word_sel),
        .way_words    (way_words),
        .refill_valid (refill_valid),
        .refill_way   (refill_way),
        .fill_rsp     (fill_rsp)
    );

endmodule

`default_nettype wire

// File: source/icache_ctrl.sv
// Fetch controller of the instruction cache.
// Splits the pc for lookup, answers hits, and runs refills on a miss.
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire logic                                           clk,
    input  wire logic                                           arst_n,
    input  wire logic                                           fetch_valid,
    input  wire icache_pkg::fetch_req_t                         fetch_req,
    output logic                                                rsp_valid,
    output icache_pkg::fetch_rsp_t                              rsp,
    output logic                                                busy,
    output logic                                                lookup_valid,
    output icache_pkg::lookup_t                                 lookup,
    output logic [1:0]                                          word_sel,
    input  wire logic                                           hit,
    input  wire logic [icache_pkg::way_w-1:0]                   hit_way,
    input  wire logic [icache_pkg::way_w-1:0]                   victim_way,
    input  wire logic [icache_pkg::ways-1:0][icache_pkg::word_w-1:0] way_words,
    output logic                                                refill_valid,
    output logic [icache_pkg::way_w-1:0]                        refill_way,
    output logic                                                fill_req_valid,
    output icache_pkg::fill_req_t                               fill_req,
    input  wire logic                                           fill_valid,
    input  wire icache_pkg::fill_rsp_t                          fill_rsp
);

    icache_pkg::ctrl_state_t state;

    // pc of the fetch in flight and the way chosen for its refill.
    logic [icache_pkg::addr_w-1:0]  pc_q;
    logic [icache_pkg::way_w-1:0]   victim_q;
    logic [1:0]                     pc_word;

    // the lookup is sent straight from the incoming pc, so the stores read in cycle k.
    assign lookup_valid = (state == icache_pkg::IDLE) && fetch_valid;
    assign lookup.index = fetch_req.pc[icache_pkg::offs_w +: icache_pkg::index_w];
    assign lookup.tag   = fetch_req.pc[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign word_sel     = fetch_req.pc[icache_pkg::offs_w-1 -: 2];

    // word offset of the held pc, used to pick the word out of a refilled line.
    assign pc_word = pc_q[icache_pkg::offs_w-1 -: 2];

    // the response is always given from REPLY, one cycle after the data is known.
    assign rsp_valid = (state == icache_pkg::REPLY);
    assign busy      = (state != icache_pkg::IDLE);

    // a line that arrives outside REFILL is dropped.
    assign refill_valid = (state == icache_pkg::REFILL) && fill_valid;
    assign refill_way   = victim_q;

    // the refill address is the held pc without its byte offset.
    assign fill_req.line_addr = pc_q[icache_pkg::addr_w-1:icache_pkg::offs_w];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= icache_pkg::IDLE;
            fill_req_valid <= 1'b0;
        end else begin
            // the refill request is a one-cycle pulse.
            fill_req_valid <= 1'b0;
            case (state)
                icache_pkg::IDLE: begin
                    if (fetch_valid) begin
                        state <= icache_pkg::LOOKUP;
                    end
                end
                icache_pkg::LOOKUP: begin
                    if (hit) begin
                        state <= icache_pkg::REPLY;
                    end else begin
                        fill_req_valid <= 1'b1;
                        state          <= icache_pkg::REFILL;
                    end
                end
                icache_pkg::REFILL: begin
                    if (fill_valid) begin
                        state <= icache_pkg::REPLY;
                    end
                end
                icache_pkg::REPLY: begin
                    state <= icache_pkg::IDLE;
                end
                default: begin
                    state <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    // pc, victim and response payload are only read while their strobe says so.
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            pc_q <= fetch_req.pc;
        end
        if (state == icache_pkg::LOOKUP) begin
            if (hit) begin
                rsp.instr <= way_words[hit_way];
                rsp.hit   <= 1'b1;
            end else begin
                victim_q <= victim_way;
            end
        end
        // on a miss the word is taken straight from the line as it arrives.
        if (refill_valid) begin
            rsp.instr <= fill_rsp.line[pc_word * icache_pkg::word_w +: icache_pkg::word_w];
            rsp.hit   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/icache_line_store.sv
// Line store of the instruction cache.
// Reads the addressed word of all four ways and writes whole refilled lines.
`timescale 1ns/1ps
`default_nettype none

module icache_line_store (
    input  wire logic                                           clk,
    input  wire logic                                           lookup_valid,
    input  wire icache_pkg::lookup_t                            lookup,
    input  wire logic [1:0]                                     word_sel,
    output logic [icache_pkg::ways-1:0][icache_pkg::word_w-1:0] way_words,
    input  wire logic                                           refill_valid,
    input  wire logic [icache_pkg::way_w-1:0]                   refill_way,
    input  wire icache_pkg::fill_rsp_t                          fill_rsp
);

    // line data of every set and way.
    logic [icache_pkg::line_w-1:0] data [icache_pkg::sets][icache_pkg::ways];

    // set of the last lookup, which is also the set a refill goes to.
    logic [icache_pkg::index_w-1:0] index_q;

    // the selected word of each way is registered, the controller picks one later.
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            index_q <= lookup.index;
            for (int w = 0; w < icache_pkg::ways; w++) begin
                way_words[w] <= data[lookup.index][w][word_sel * icache_pkg::word_w +:
                                                      icache_pkg::word_w];
            end
        end
    end

    // a refill writes the whole line at once.
    always_ff @(posedge clk) begin
        if (refill_valid) begin
            data[index_q][refill_way] <= fill_rsp.line;
        end
    end

endmodule

`default_nettype wire

// File: source/icache_tag_store.sv
// Tag store of the instruction cache.
// Keeps tags, valid bits and a three-bit pseudo-LRU tree for every set.
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          flush,
    input  wire logic                          lookup_valid,
    input  wire icache_pkg::lookup_t           lookup,
    output logic                               hit,
    output logic [icache_pkg::way_w-1:0]       hit_way,
    output logic [icache_pkg::way_w-1:0]       victim_way,
    input  wire logic                          refill_valid,
    input  wire logic [icache_pkg::way_w-1:0]  refill_way
);

    // tag memory has no reset, a way only counts once its valid bit is set.
    logic [icache_pkg::tag_w-1:0] tags [icache_pkg::sets][icache_pkg::ways];
    logic [icache_pkg::ways-1:0]  valid [icache_pkg::sets];

    // tree bits per set. root picks the pair, left and right pick inside a pair.
    logic tree_root  [icache_pkg::sets];
    logic tree_left  [icache_pkg::sets];
    logic tree_right [icache_pkg::sets];

    // the lookup is held until the next one, so a refill writes to the same set.
    icache_pkg::lookup_t lk_q;
    logic                lk_valid_q;

    logic [icache_pkg::ways-1:0]  match;
    logic                         touch_valid;
    logic [icache_pkg::way_w-1:0] touch_way;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lk_q       <= '0;
            lk_valid_q <= 1'b0;
        end else begin
            lk_valid_q <= lookup_valid;
            if (lookup_valid) begin
                lk_q <= lookup;
            end
        end
    end

    // compare the held tag against every way of the held set.
    always_comb begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            match[w] = valid[lk_q.index][w] && (tags[lk_q.index][w] == lk_q.tag);
        end
    end

    // hit is only reported in the cycle after a lookup.
    assign hit = lk_valid_q && (|match);

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (match[w]) begin
                hit_way = w[icache_pkg::way_w-1:0];
            end
        end
    end

    // the victim comes from the tree alone, invalid ways are not preferred.
    assign victim_way = tree_root[lk_q.index] ? {1'b1, tree_right[lk_q.index]}
                                              : {1'b0, tree_left[lk_q.index]};

    // hits and refills never fall in the same cycle, so one touch port serves both.
    assign touch_valid = hit || refill_valid;
    assign touch_way   = refill_valid ? refill_way : hit_way;

    // the refill line lands in the chosen way of the held set.
    always_ff @(posedge clk) begin
        if (refill_valid) begin
            tags[lk_q.index][refill_way] <= lk_q.tag;
        end
    end

    // flush wins over any touch or refill in the same cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < icache_pkg::sets; s++) begin
                valid[s]      <= '0;
                tree_root[s]  <= 1'b0;
                tree_left[s]  <= 1'b0;
                tree_right[s] <= 1'b0;
            end
        end else if (flush) begin
            for (int s = 0; s < icache_pkg::sets; s++) begin
                valid[s]      <= '0;
                tree_root[s]  <= 1'b0;
                tree_left[s]  <= 1'b0;
                tree_right[s] <= 1'b0;
            end
        end else begin
            if (refill_valid) begin
                valid[lk_q.index][refill_way] <= 1'b1;
            end
            // a touch points the tree away from the touched way.
            if (touch_valid) begin
                tree_root[lk_q.index] <= ~touch_way[1];
                if (touch_way[1]) begin
                    tree_right[lk_q.index] <= ~touch_way[0];
                end else begin
                    tree_left[lk_q.index] <= ~touch_way[0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/icache_pkg.sv
// Shared definitions for the four-way L1 instruction cache.
// Holds the cache geometry, the request and response structs and the FSM state type.
`default_nettype none

package icache_pkg;

    // program counter and instruction widths.
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // four ways of four sets, sixteen bytes per line.
    localparam int ways       = 4;
    localparam int sets       = 4;
    localparam int line_bytes = 16;

    // derived field widths of the program counter.
    localparam int line_w  = line_bytes * 8;
    localparam int offs_w  = $clog2(line_bytes);
    localparam int index_w = $clog2(sets);
    localparam int tag_w   = addr_w - index_w - offs_w;
    localparam int way_w   = $clog2(ways);

    // a fetch carries only the word-aligned program counter.
    typedef struct packed {
        logic [addr_w-1:0] pc;
    } fetch_req_t;

    // the response returns the instruction and whether it came from a hit.
    typedef struct packed {
        logic [word_w-1:0] instr;
        logic              hit;
    } fetch_rsp_t;

    // refills are requested by line address, so the byte offset is dropped.
    typedef struct packed {
        logic [addr_w-offs_w-1:0] line_addr;
    } fill_req_t;

    // one whole line, lowest addressed word in the lowest bits.
    typedef struct packed {
        logic [line_w-1:0] line;
    } fill_rsp_t;

    // set index and tag of the program counter under lookup.
    typedef struct packed {
        logic [index_w-1:0] index;
        logic [tag_w-1:0]   tag;
    } lookup_t;

    // controller FSM states.
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        REPLY
    } ctrl_state_t;

endpackage

`default_nettype wire
